/* verilog/icache_pkg.sv */
package icache_pkg;

    // address layout
    localparam int addr_w         = 32;
    localparam int line_bytes     = 32;
    localparam int words_per_line = line_bytes / 4;
    localparam int pairs_per_line = words_per_line / 2;
    localparam int tag_w          = 20;

    // fetches with this bit set skip the cache
    localparam int uncached_bit = 31;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // element 0 is the instruction at the lower address
    typedef logic [1:0][31:0] fetch_pair_t;

endpackage

/* verilog/icache_sram.sv */
`timescale 1ns/100ps

module icache_sram #(
    parameter int  depth   = 64,
    parameter type entry_t = logic [31:0]
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(depth)-1:0] raddr_i,
    input  logic                     ren_i,
    output entry_t                   rdata_o,
    input  logic [$clog2(depth)-1:0] waddr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else if (ren_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

/* verilog/icache_lookup.sv */
`timescale 1ns/100ps

module icache_lookup
    import icache_pkg::*;
#(
    parameter int sets = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [addr_w-1:0]         req_pc_i,
    input  logic                      hold_i,
    input  logic                      replay_i,
    output logic                      s1_valid_o,
    input  logic                      s1_ready_i,
    output logic [addr_w-1:0]         s1_pc_o,
    output logic [$clog2(sets)-1:0]   tag_raddr_o,
    output logic [$clog2(sets)+1:0]   data_raddr_o,
    output logic                      sram_ren_o
);

    localparam int idx_w = $clog2(sets);
    localparam int off_w = $clog2(line_bytes);

    logic              s1_valid_q;
    logic [addr_w-1:0] s1_pc_q;
    logic [addr_w-1:0] rd_pc;
    logic              accept;

    // take a new request only if stage 2 frees our slot
    assign req_ready_o = !hold_i && (!s1_valid_q || s1_ready_i);
    assign accept      = req_valid_i && req_ready_o;

    // replay re-reads the held pc after a refill
    assign rd_pc        = replay_i ? s1_pc_q : req_pc_i;
    assign tag_raddr_o  = rd_pc[off_w +: idx_w];
    // set index followed by pair offset
    assign data_raddr_o = rd_pc[3 +: idx_w + 2];
    assign sram_ren_o   = accept || replay_i;

    assign s1_valid_o = s1_valid_q;
    assign s1_pc_o    = s1_pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q <= 1'b0;
        end else if (accept) begin
            s1_valid_q <= 1'b1;
        end else if (s1_ready_i) begin
            s1_valid_q <= 1'b0;
        end
    end

    // pc travels alongside the sram read latency
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_pc_q <= {req_pc_i[addr_w-1:3], 3'b000};
        end
    end

endmodule

/* verilog/icache_hit_select.sv */
`timescale 1ns/100ps

module icache_hit_select
    import icache_pkg::*;
#(
    parameter int sets = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              s1_valid_i,
    output logic              s1_ready_o,
    input  logic [addr_w-1:0] s1_pc_i,
    input  tag_entry_t        tag0_i,
    input  tag_entry_t        tag1_i,
    input  fetch_pair_t       data0_i,
    input  fetch_pair_t       data1_i,
    output logic              miss_valid_o,
    output logic [addr_w-1:0] miss_pc_o,
    output logic              miss_uncached_o,
    input  logic              fill_done_i,
    input  fetch_pair_t       fill_pair_i,
    output logic [1:0]        hit_way_o,
    output logic              resp_valid_o,
    input  logic              resp_ready_i,
    output logic [addr_w-1:0] resp_pc_o,
    output fetch_pair_t       resp_insts_o
);

    // tag sits right above the index so no address bit is skipped
    localparam int tag_lsb = $clog2(line_bytes) + $clog2(sets);

    logic [tag_w-1:0]  pc_tag;
    logic              uncached;
    logic [1:0]        hit;
    fetch_pair_t       hit_pair;
    logic              take;
    logic              resp_valid_q;
    logic              wait_q;
    logic              miss_q;
    logic [addr_w-1:0] pc_q;
    fetch_pair_t       insts_q;
    logic [1:0]        way_q;

    assign pc_tag   = s1_pc_i[tag_lsb +: tag_w];
    assign uncached = s1_pc_i[uncached_bit];
    assign hit[0]   = !uncached && tag0_i.valid && (tag0_i.tag == pc_tag);
    assign hit[1]   = !uncached && tag1_i.valid && (tag1_i.tag == pc_tag);
    assign hit_pair = hit[1] ? data1_i : data0_i;

    // frozen while a refill is outstanding
    assign s1_ready_o = !wait_q && (!resp_valid_q || resp_ready_i);
    assign take       = s1_valid_i && s1_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
            wait_q       <= 1'b0;
            miss_q       <= 1'b0;
        end else begin
            // one-cycle report to refill
            miss_q <= take && !(|hit);
            if (fill_done_i) begin
                resp_valid_q <= 1'b1;
                wait_q       <= 1'b0;
            end else if (take) begin
                resp_valid_q <= |hit;
                wait_q       <= !(|hit);
            end else if (resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q    <= s1_pc_i;
            insts_q <= hit_pair;
            way_q   <= hit;
        end else if (fill_done_i) begin
            insts_q <= fill_pair_i;
            way_q   <= '0;
        end
    end

    assign resp_valid_o    = resp_valid_q;
    assign resp_pc_o       = pc_q;
    assign resp_insts_o    = insts_q;
    assign hit_way_o       = way_q;
    assign miss_valid_o    = miss_q;
    assign miss_pc_o       = pc_q;
    assign miss_uncached_o = pc_q[uncached_bit];

endmodule

/* verilog/icache_refill.sv */
`timescale 1ns/100ps

module icache_refill
    import icache_pkg::*;
#(
    parameter int sets = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss_valid_i,
    input  logic [addr_w-1:0]       miss_pc_i,
    input  logic                    miss_uncached_i,
    output logic                    fill_done_o,
    output fetch_pair_t             fill_pair_o,
    output logic                    hold_o,
    output logic                    replay_o,
    input  logic                    inv_valid_i,
    input  logic [$clog2(sets)-1:0] inv_index_i,
    output logic                    inv_ready_o,
    output logic [1:0]              tag_we_o,
    output logic [$clog2(sets)-1:0] tag_waddr_o,
    output tag_entry_t              tag_wdata_o,
    output logic [1:0]              data_we_o,
    output logic [$clog2(sets)+1:0] data_waddr_o,
    output fetch_pair_t             data_wdata_o,
    output logic                    m_axi_arvalid_o,
    input  logic                    m_axi_arready_i,
    output logic [addr_w-1:0]       m_axi_araddr_o,
    input  logic                    m_axi_rvalid_i,
    output logic                    m_axi_rready_o,
    input  logic [31:0]             m_axi_rdata_i
);

    localparam int idx_w   = $clog2(sets);
    localparam int off_w   = $clog2(line_bytes);
    localparam int tag_lsb = off_w + idx_w;

    typedef enum logic [2:0] {
        st_sweep,
        st_idle,
        st_addr,
        st_data,
        st_done
    } state_t;

    state_t            state_q;
    logic [idx_w-1:0]  sweep_q;
    logic [sets-1:0]   victim_q;
    logic [addr_w-1:0] pc_q;
    logic              unc_q;
    logic              way_q;
    logic [2:0]        beat_q;
    logic [31:0]       lo_q;
    fetch_pair_t       pair_q;
    logic [idx_w-1:0]  idx;
    fetch_pair_t       beat_pair;
    logic              beat_take;
    logic              last_beat;
    logic              inv_take;

    assign idx       = pc_q[off_w +: idx_w];
    assign beat_take = (state_q == st_data) && m_axi_rvalid_i;
    assign beat_pair = {m_axi_rdata_i, lo_q};
    // a line is eight beats, an uncached pair two
    assign last_beat = unc_q ? beat_q[0] : &beat_q;

    // a pending miss wins over an invalidate
    assign inv_ready_o = (state_q == st_idle) && !miss_valid_i;
    assign inv_take    = inv_valid_i && inv_ready_o;
    assign hold_o      = (state_q != st_idle) || inv_take;
    assign fill_done_o = (state_q == st_done);
    assign replay_o    = (state_q == st_done) && !unc_q;
    assign fill_pair_o = pair_q;

    assign m_axi_arvalid_o = (state_q == st_addr);
    assign m_axi_rready_o  = (state_q == st_data);
    assign m_axi_araddr_o  = unc_q ? {pc_q[addr_w-1:3], beat_q[0], 2'b00}
                                   : {pc_q[addr_w-1:off_w], beat_q, 2'b00};

    // sram write port
    always_comb begin
        tag_we_o     = '0;
        tag_waddr_o  = idx;
        tag_wdata_o  = '0;
        data_we_o    = '0;
        data_waddr_o = {idx, beat_q[2:1]};
        data_wdata_o = beat_pair;
        case (state_q)
            st_sweep: begin
                tag_we_o    = 2'b11;
                tag_waddr_o = sweep_q;
            end
            st_idle: begin
                if (inv_take) begin
                    tag_we_o    = 2'b11;
                    tag_waddr_o = inv_index_i;
                end
            end
            st_data: begin
                // every second beat completes a pair
                if (beat_take && !unc_q && beat_q[0]) begin
                    data_we_o[way_q] = 1'b1;
                    if (last_beat) begin
                        tag_we_o[way_q]   = 1'b1;
                        tag_wdata_o.valid = 1'b1;
                        tag_wdata_o.tag   = pc_q[tag_lsb +: tag_w];
                    end
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= st_sweep;
            sweep_q  <= '0;
            victim_q <= '0;
        end else begin
            case (state_q)
                st_sweep: begin
                    sweep_q <= sweep_q + 1'b1;
                    if (sweep_q == idx_w'(sets - 1)) begin
                        state_q <= st_idle;
                    end
                end
                st_idle: begin
                    if (miss_valid_i) begin
                        state_q <= st_addr;
                    end
                end
                st_addr: begin
                    if (m_axi_arready_i) begin
                        state_q <= st_data;
                    end
                end
                st_data: begin
                    if (beat_take && last_beat) begin
                        state_q <= st_done;
                        // next fill of this set goes to the other way
                        if (!unc_q) begin
                            victim_q[idx] <= !victim_q[idx];
                        end
                    end else if (beat_take) begin
                        state_q <= st_addr;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && miss_valid_i) begin
            pc_q   <= miss_pc_i;
            unc_q  <= miss_uncached_i;
            way_q  <= victim_q[miss_pc_i[off_w +: idx_w]];
            beat_q <= '0;
        end
        if (beat_take) begin
            beat_q <= beat_q + 1'b1;
            if (!beat_q[0]) begin
                lo_q <= m_axi_rdata_i;
            end else if (unc_q || (beat_q[2:1] == pc_q[3 +: 2])) begin
                // the pair the fetch asked for
                pair_q <= beat_pair;
            end
        end
    end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
#(
    parameter int sets = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  logic [addr_w-1:0]       req_pc_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output logic [addr_w-1:0]       resp_pc_o,
    output fetch_pair_t             resp_insts_o,
    input  logic                    inv_valid_i,
    input  logic [$clog2(sets)-1:0] inv_index_i,
    output logic                    inv_ready_o,
    output logic                    m_axi_arvalid_o,
    input  logic                    m_axi_arready_i,
    output logic [addr_w-1:0]       m_axi_araddr_o,
    input  logic                    m_axi_rvalid_i,
    output logic                    m_axi_rready_o,
    input  logic [31:0]             m_axi_rdata_i
);

    localparam int idx_w = $clog2(sets);

    logic              s1_valid;
    logic              s1_ready;
    logic [addr_w-1:0] s1_pc;
    logic [idx_w-1:0]  tag_raddr;
    logic [idx_w+1:0]  data_raddr;
    logic              sram_ren;
    tag_entry_t        tag_rdata [2];
    fetch_pair_t       data_rdata [2];

    logic              miss_valid;
    logic [addr_w-1:0] miss_pc;
    logic              miss_uncached;
    logic              fill_done;
    fetch_pair_t       fill_pair;
    logic              hold;
    logic              replay;

    logic [1:0]        tag_we;
    logic [idx_w-1:0]  tag_waddr;
    tag_entry_t        tag_wdata;
    logic [1:0]        data_we;
    logic [idx_w+1:0]  data_waddr;
    fetch_pair_t       data_wdata;

    icache_lookup #(
        .sets(sets)
    ) i_lookup (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_ready_o,
        .req_pc_i,
        .hold_i       (hold),
        .replay_i     (replay),
        .s1_valid_o   (s1_valid),
        .s1_ready_i   (s1_ready),
        .s1_pc_o      (s1_pc),
        .tag_raddr_o  (tag_raddr),
        .data_raddr_o (data_raddr),
        .sram_ren_o   (sram_ren)
    );

    // one tag and one data array per way
    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_sram #(
            .depth   (sets),
            .entry_t (tag_entry_t)
        ) i_tag_sram (
            .clk,
            .rst_n,
            .raddr_i (tag_raddr),
            .ren_i   (sram_ren),
            .rdata_o (tag_rdata[w]),
            .waddr_i (tag_waddr),
            .we_i    (tag_we[w]),
            .wdata_i (tag_wdata)
        );

        icache_sram #(
            .depth   (sets * pairs_per_line),
            .entry_t (fetch_pair_t)
        ) i_data_sram (
            .clk,
            .rst_n,
            .raddr_i (data_raddr),
            .ren_i   (sram_ren),
            .rdata_o (data_rdata[w]),
            .waddr_i (data_waddr),
            .we_i    (data_we[w]),
            .wdata_i (data_wdata)
        );
    end

    icache_hit_select #(
        .sets(sets)
    ) i_hit_select (
        .clk,
        .rst_n,
        .s1_valid_i      (s1_valid),
        .s1_ready_o      (s1_ready),
        .s1_pc_i         (s1_pc),
        .tag0_i          (tag_rdata[0]),
        .tag1_i          (tag_rdata[1]),
        .data0_i         (data_rdata[0]),
        .data1_i         (data_rdata[1]),
        .miss_valid_o    (miss_valid),
        .miss_pc_o       (miss_pc),
        .miss_uncached_o (miss_uncached),
        .fill_done_i     (fill_done),
        .fill_pair_i     (fill_pair),
        .hit_way_o       (),
        .resp_valid_o,
        .resp_ready_i,
        .resp_pc_o,
        .resp_insts_o
    );

    icache_refill #(
        .sets(sets)
    ) i_refill (
        .clk,
        .rst_n,
        .miss_valid_i    (miss_valid),
        .miss_pc_i       (miss_pc),
        .miss_uncached_i (miss_uncached),
        .fill_done_o     (fill_done),
        .fill_pair_o     (fill_pair),
        .hold_o          (hold),
        .replay_o        (replay),
        .inv_valid_i,
        .inv_index_i,
        .inv_ready_o,
        .tag_we_o        (tag_we),
        .tag_waddr_o     (tag_waddr),
        .tag_wdata_o     (tag_wdata),
        .data_we_o       (data_we),
        .data_waddr_o    (data_waddr),
        .data_wdata_o    (data_wdata),
        .m_axi_arvalid_o,
        .m_axi_arready_i,
        .m_axi_araddr_o,
        .m_axi_rvalid_i,
        .m_axi_rready_o,
        .m_axi_rdata_i
    );

endmodule

/* tests/icache_mem.svh */
// memory content returned by the AXI slave, a fixed scramble of the byte address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5bd1e995;
    x = x * 32'h01000193;
    x = {x[15:0], x[31:16]} ^ addr;
    return x;
endfunction

/* tests/icache_checker.sv */
`timescale 1ns/100ps

module icache_checker #(
    parameter int sets = 64
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid_i,
    input  logic                    req_ready_i,
    input  logic [31:0]             req_pc_i,
    input  logic                    resp_valid_i,
    input  logic                    resp_ready_i,
    input  logic [31:0]             resp_pc_i,
    input  logic [63:0]             resp_insts_i,
    input  logic                    inv_valid_i,
    input  logic                    inv_ready_i,
    input  logic [$clog2(sets)-1:0] inv_index_i,
    input  logic                    arvalid_i,
    input  logic                    arready_i,
    input  logic [31:0]             araddr_i,
    input  logic                    rvalid_i,
    input  logic                    rready_i,
    input  logic                    done_i,
    output int                      data_errs_o,
    output int                      bus_errs_o,
    output int                      flow_errs_o,
    output int                      n_resp_o
);

    `include "icache_mem.svh"

    localparam int idx_w = $clog2(sets);

    // outstanding requests oldest first and the hit or miss each will see
    logic [31:0] pc_q [$];
    logic        miss_q [$];

    // tag array model holding one line address per way
    logic        valid_tab [sets][2];
    logic [26:0] line_tab [sets][2];
    logic        toggle [sets];

    int          ar_cnt;
    int          r_cnt;
    int          n_acc;
    int          n_resp;
    int          since_rst;
    int          data_errs = 0;
    int          bus_errs = 0;
    int          flow_errs = 0;
    logic        held_q;
    logic [31:0] held_pc;
    logic [63:0] held_insts;
    logic        ar_wait;
    logic [31:0] ar_addr_q;
    logic        closed;

    assign data_errs_o = data_errs;
    assign bus_errs_o  = bus_errs;
    assign flow_errs_o = flow_errs;
    assign n_resp_o    = n_resp;

    function automatic logic line_resident(input logic [31:0] pc);
        int s;
        s = pc[5 +: idx_w];
        if (pc[31]) begin
            return 1'b0;
        end
        for (int w = 0; w < 2; w++) begin
            if (valid_tab[s][w] && (line_tab[s][w] == pc[31:5])) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int beats_for(input logic [31:0] pc);
        return pc[31] ? 2 : 8;
    endfunction

    // uncached reads fetch the pair while cached reads walk the line upwards
    function automatic logic [31:0] read_addr(input logic [31:0] pc, input int n);
        if (pc[31]) begin
            return pc + 32'(n * 4);
        end
        return {pc[31:5], 5'b00000} + 32'(n * 4);
    endfunction

    task automatic clear_model();
        for (int s = 0; s < sets; s++) begin
            valid_tab[s][0] = 1'b0;
            valid_tab[s][1] = 1'b0;
            toggle[s]       = 1'b0;
        end
        pc_q.delete();
        miss_q.delete();
        ar_cnt    = 0;
        r_cnt     = 0;
        n_acc     = 0;
        n_resp    = 0;
        since_rst = 0;
        held_q    = 1'b0;
        ar_wait   = 1'b0;
        closed    = 1'b0;
    endtask

    task automatic check_response();
        logic [31:0] pc;
        logic        miss;
        int          exp_reads;
        n_resp++;
        if (pc_q.size() == 0) begin
            $display("flow: response for %h at %0t with no request outstanding", resp_pc_i, $time);
            flow_errs++;
            return;
        end
        pc        = pc_q.pop_front();
        miss      = miss_q.pop_front();
        exp_reads = miss ? beats_for(pc) : 0;
        if (resp_pc_i != pc) begin
            $display("ERROR %0t: response pc %h, expected %h", $time, resp_pc_i, pc);
            data_errs++;
        end
        if ((resp_insts_i[31:0] != mem_word(pc)) || (resp_insts_i[63:32] != mem_word(pc + 4))) begin
            $display("ERROR %0t: pc %h returned %h, expected %h_%h", $time, pc, resp_insts_i,
                     mem_word(pc + 4), mem_word(pc));
            data_errs++;
        end
        if ((ar_cnt != exp_reads) || (r_cnt != exp_reads)) begin
            $display("ERROR %0t: pc %h took %0d reads and %0d beats, expected %0d", $time, pc,
                     ar_cnt, r_cnt, exp_reads);
            bus_errs++;
        end
        ar_cnt = 0;
        r_cnt  = 0;
    endtask

    task automatic check_read();
        logic [31:0] pc;
        if ((pc_q.size() == 0) || !miss_q[0]) begin
            $display("ERROR %0t: read of %h with no miss pending", $time, araddr_i);
            bus_errs++;
        end else begin
            pc = pc_q[0];
            if (ar_cnt >= beats_for(pc)) begin
                $display("ERROR %0t: extra read of %h for pc %h", $time, araddr_i, pc);
                bus_errs++;
            end else if (araddr_i != read_addr(pc, ar_cnt)) begin
                $display("ERROR %0t: read address %h, expected %h", $time, araddr_i,
                         read_addr(pc, ar_cnt));
                bus_errs++;
            end
        end
        ar_cnt++;
    endtask

    task automatic take_beat();
        logic [31:0] pc;
        int          s;
        r_cnt++;
        if (r_cnt > ar_cnt) begin
            $display("bus: data beat taken at %0t without a read address", $time);
            bus_errs++;
        end
        if ((pc_q.size() > 0) && miss_q[0] && (r_cnt == 8)) begin
            pc = pc_q[0];
            if (!pc[31]) begin
                s = pc[5 +: idx_w];
                line_tab[s][toggle[s]]  = pc[31:5];
                valid_tab[s][toggle[s]] = 1'b1;
                toggle[s]               = !toggle[s];
                // the request waiting in stage 1 re-reads its tags after a line fill
                if (pc_q.size() > 1) begin
                    miss_q[1] = !line_resident(pc_q[1]);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            clear_model();
        end else begin
            if ((since_rst == 0) && (resp_valid_i || arvalid_i || rready_i)) begin
                $display("flow: outputs not idle in the first cycle after reset");
                flow_errs++;
            end
            if ((since_rst < sets) && (req_ready_i || inv_ready_i)) begin
                $display("flow: ready raised at %0t during the tag reset sweep", $time);
                flow_errs++;
            end
            since_rst++;
            if (held_q && (!resp_valid_i || (resp_pc_i != held_pc) ||
                           (resp_insts_i != held_insts))) begin
                $display("ERROR %0t: held response for %h dropped or changed", $time, held_pc);
                data_errs++;
            end
            held_q     = resp_valid_i && !resp_ready_i;
            held_pc    = resp_pc_i;
            held_insts = resp_insts_i;
            if (ar_wait && (!arvalid_i || (araddr_i != ar_addr_q))) begin
                $display("bus: read address dropped or changed at %0t before arready", $time);
                bus_errs++;
            end
            ar_wait   = arvalid_i && !arready_i;
            ar_addr_q = araddr_i;
            if ((ar_cnt > r_cnt) && arvalid_i) begin
                $display("bus: read of %h requested at %0t while another read is outstanding",
                         araddr_i, $time);
                bus_errs++;
            end
            if ((ar_cnt > r_cnt) && !rready_i) begin
                $display("bus: rready low at %0t while a beat is awaited", $time);
                bus_errs++;
            end
            if (resp_valid_i && resp_ready_i) begin
                check_response();
            end
            if (inv_valid_i && inv_ready_i) begin
                valid_tab[inv_index_i][0] = 1'b0;
                valid_tab[inv_index_i][1] = 1'b0;
            end
            if (req_valid_i && req_ready_i) begin
                pc_q.push_back({req_pc_i[31:3], 3'b000});
                miss_q.push_back(!line_resident({req_pc_i[31:3], 3'b000}));
                n_acc++;
            end
            if (arvalid_i && arready_i) begin
                check_read();
            end
            if (rvalid_i && rready_i) begin
                take_beat();
            end
            if (done_i && !closed) begin
                closed = 1'b1;
                if ((n_acc != n_resp) || (pc_q.size() != 0)) begin
                    $display("flow: %0d requests accepted but %0d responses returned",
                             n_acc, n_resp);
                    flow_errs++;
                end
            end
        end
    end

endmodule

/* tests/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

    localparam int sets         = 64;
    localparam int idx_w        = $clog2(sets);
    localparam int n_req        = 2000;
    localparam int max_cycles   = n_req * 200;
    localparam int drain_cycles = 16;

    `include "icache_mem.svh"

    logic             clk;
    logic             rst_n;
    logic             req_valid_i;
    logic             req_ready_o;
    logic [31:0]      req_pc_i;
    logic             resp_valid_o;
    logic             resp_ready_i;
    logic [31:0]      resp_pc_o;
    logic [63:0]      resp_insts_o;
    logic             inv_valid_i;
    logic [idx_w-1:0] inv_index_i;
    logic             inv_ready_o;
    logic             m_axi_arvalid_o;
    logic             m_axi_arready_i;
    logic [31:0]      m_axi_araddr_o;
    logic             m_axi_rvalid_i;
    logic             m_axi_rready_o;
    logic [31:0]      m_axi_rdata_i;

    integer           seed = 32'hc9f857aa;
    logic             stim_done;
    logic             done;
    int               data_errs;
    int               bus_errs;
    int               flow_errs;
    int               n_resp;

    icache_top #(
        .sets(sets)
    ) i_icache_top (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_ready_o,
        .req_pc_i,
        .resp_valid_o,
        .resp_ready_i,
        .resp_pc_o,
        .resp_insts_o,
        .inv_valid_i,
        .inv_index_i,
        .inv_ready_o,
        .m_axi_arvalid_o,
        .m_axi_arready_i,
        .m_axi_araddr_o,
        .m_axi_rvalid_i,
        .m_axi_rready_o,
        .m_axi_rdata_i
    );

    icache_checker #(
        .sets(sets)
    ) i_checker (
        .clk,
        .rst_n,
        .req_valid_i,
        .req_ready_i  (req_ready_o),
        .req_pc_i,
        .resp_valid_i (resp_valid_o),
        .resp_ready_i,
        .resp_pc_i    (resp_pc_o),
        .resp_insts_i (resp_insts_o),
        .inv_valid_i,
        .inv_ready_i  (inv_ready_o),
        .inv_index_i,
        .arvalid_i    (m_axi_arvalid_o),
        .arready_i    (m_axi_arready_i),
        .araddr_i     (m_axi_araddr_o),
        .rvalid_i     (m_axi_rvalid_i),
        .rready_i     (m_axi_rready_o),
        .done_i       (done),
        .data_errs_o  (data_errs),
        .bus_errs_o   (bus_errs),
        .flow_errs_o  (flow_errs),
        .n_resp_o     (n_resp)
    );

    // six sets spread over the index range
    function automatic logic [idx_w-1:0] pool_set(input int k);
        return idx_w'((k * 11 + 3) % sets);
    endfunction

    task automatic draw_pc(output logic [31:0] pc);
        int         k;
        logic [19:0] tag;
        k   = ($random(seed) & 32'h7fff) % 6;
        // four tags per set against two ways
        tag = 20'h00040 + 20'(($random(seed) & 3) * 32'h531);
        pc  = 32'(tag) << (5 + idx_w);
        pc[5 +: idx_w] = pool_set(k);
        pc[4:0] = 5'($random(seed));
        pc[31]  = (($random(seed) & 7) == 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] pc;
        logic        taken;
        int          gap;
        rst_n       = 1'b0;
        req_valid_i = 1'b0;
        req_pc_i    = '0;
        stim_done   = 1'b0;
        done        = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_req; i++) begin
            gap = $random(seed) & 7;
            // most requests follow straight on
            if (gap > 3) begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            draw_pc(pc);
            req_valid_i = 1'b1;
            req_pc_i    = pc;
            do begin
                @(negedge clk);
                taken = req_ready_o;
                @(posedge clk);
                #1;
            end while (!taken);
            req_valid_i = 1'b0;
        end
        stim_done = 1'b1;
        while (n_resp < n_req) begin
            @(posedge clk);
            #1;
        end
        // a few more cycles to catch a stray extra response
        repeat (drain_cycles) begin
            @(posedge clk);
            #1;
        end
        done = 1'b1;
        @(posedge clk);
        #1;
        $display("closing: data errors %0d, bus errors %0d, flow errors %0d",
                 data_errs, bus_errs, flow_errs);
        if ((data_errs + bus_errs + flow_errs) == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // random back-pressure on the response side
    initial begin
        resp_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            resp_ready_i = (($random(seed) & 3) != 0);
        end
    end

    initial begin
        logic taken;
        inv_valid_i = 1'b0;
        inv_index_i = '0;
        @(posedge rst_n);
        while (!stim_done) begin
            @(posedge clk);
            #1;
            if (($random(seed) & 63) == 0) begin
                inv_valid_i = 1'b1;
                inv_index_i = pool_set(($random(seed) & 32'h7fff) % 6);
                do begin
                    @(negedge clk);
                    taken = inv_ready_o;
                    @(posedge clk);
                    #1;
                end while (!taken);
                inv_valid_i = 1'b0;
            end
        end
    end

    // AXI4-Lite slave with random delays
    initial begin
        logic [31:0] addr;
        logic        taken;
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i  = 1'b0;
        m_axi_rdata_i   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (m_axi_arvalid_o) begin
                repeat ($random(seed) & 3) begin
                    @(posedge clk);
                    #1;
                end
                addr            = m_axi_araddr_o;
                m_axi_arready_i = 1'b1;
                @(posedge clk);
                #1;
                m_axi_arready_i = 1'b0;
                repeat ($random(seed) & 3) begin
                    @(posedge clk);
                    #1;
                end
                m_axi_rvalid_i = 1'b1;
                m_axi_rdata_i  = mem_word(addr);
                do begin
                    @(negedge clk);
                    taken = m_axi_rready_o;
                    @(posedge clk);
                    #1;
                end while (!taken);
                m_axi_rvalid_i = 1'b0;
            end
        end
    end

endmodule

/* vlog.f */
+incdir+tests
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_lookup.sv
verilog/icache_hit_select.sv
verilog/icache_refill.sv
verilog/icache_top.sv
tests/icache_checker.sv
tests/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_sram.sv
      - verilog/icache_lookup.sv
      - verilog/icache_hit_select.sv
      - verilog/icache_refill.sv
      - verilog/icache_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/icache_checker.sv
      - tests/tb_icache.sv
